// File: Makefile
VERILATOR ?= verilator
TOP       := sram_io_tb
RTL_TOP   := sram_io_top
FILELIST  := sram_io.f
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing
PASS_MSG  := TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// File: dv/scpu_chip_model.sv
/*
 * Behavioral test chip: 17-bit scan register, 512x8 SRAM, ready flag
 * Shifts on the controller's edges and moves data between scan and SRAM on load
 */

`timescale 1ns/1ps
`default_nettype none

module scpu_chip_model
(
    input  wire logic clk,
    input  wire logic reset_n,
    input  wire logic load,
    input  wire logic mod0,
    input  wire logic mod1,
    input  wire logic read_dir,  // Serial direction, the mode pins hide it
    input  wire logic si,
    output      logic so,
    output      logic rdy
);

    logic [16:0] scan_q  = '0;   // {addr, data}
    logic [4:0]  count_q = '0;   // Shifts still to do
    logic [1:0]  hold_q  = '0;   // Cycles of ready low left
    logic [7:0]  mem [0:511];

    initial
    begin
        for (int i = 0; i < 512; i++)
            mem[i] = i[7:0] ^ i[8:1];  // Every address bit matters
    end

    always @(posedge clk)
    begin
        if (!reset_n)
        begin
            scan_q  <= '0;
            count_q <= '0;
            hold_q  <= '0;
        end
        else if (load)
        begin
            hold_q <= 2'd3;
            if (mod0 && mod1)
                mem[scan_q[16:8]] <= scan_q[7:0];   // Scan to SRAM
            else if (mod0)
                scan_q[7:0] <= mem[scan_q[16:8]];   // SRAM to scan
            else if (read_dir)
            begin
                scan_q  <= {si, scan_q[16:1]};      // Read starts on the load edge
                count_q <= 5'd16;
            end
            else
                count_q <= 5'd17;                   // Write starts one edge later
        end
        else
        begin
            if (hold_q != 2'd0)
                hold_q <= hold_q - 2'd1;
            if (count_q != 5'd0)
            begin
                scan_q  <= {si, scan_q[16:1]};
                count_q <= count_q - 5'd1;
            end
        end
    end

    assign so  = scan_q[0];
    assign rdy = (hold_q == 2'd0);

endmodule

`default_nettype wire

// File: dv/sram_io_tb.sv
/*
 * Testbench for the test chip SRAM link controller
 * CPU register writes, chip model, reference model and readback checks
 */

`timescale 1ns/1ps
`default_nettype none

module sram_io_tb;

    localparam int clk_period   = 4;
    localparam int reset_cycles = 10;
    localparam int frame_cycles = 25;  // One transfer with margin
    localparam int max_frames   = 50;
    localparam int bw           = sram_io_regs_pkg::bus_width;

    logic          csi_clk = 1'b0;
    logic          rsi_reset_n;
    logic [bw-1:0] avs_cpuctrl_writedata;
    logic          avs_cpuctrl_write;
    logic [bw-1:0] avs_sram_addr_writedata;
    logic          avs_sram_addr_write;
    logic [bw-1:0] avs_sram_data_writedata;
    logic          avs_sram_data_write;
    logic [bw-1:0] avs_cpustat_readdata;
    logic [bw-1:0] avs_sram_addr_readdata;
    logic [bw-1:0] avs_sram_data_readdata;
    logic          coe_ctrl_bgn_export;
    logic          coe_ctrl_load_export;
    logic          coe_ctrl_mod0_export;
    logic          coe_ctrl_mod1_export;
    logic          coe_ctrl_si_export;
    logic          coe_ctrl_so_export;
    logic          coe_ctrl_rdy_export;
    logic          read_dir;                 // Chip model hint

    // Reference state: chip scan register, chip SRAM, controller frame
    sram_io_frame_pkg::frame_t ref_scan;
    sram_io_frame_pkg::frame_t ref_frame;
    logic [7:0]                ref_mem [0:511];
    sram_io_frame_pkg::frame_t cur_regs;     // Address and data registers as written
    sram_io_frame_pkg::frame_t stim;
    logic [7:0]                first_data;
    logic [1:0]                exp_mode;
    logic                      exp_bgn;
    logic [31:0]               lfsr_state = 32'hbdf1_3fe4;

    int checks;
    int errors;
    int test_errors;
    int test_num;
    int load_pulses;
    int busy_cycles;

    sram_io_top sram_io_top_inst (.*);

    scpu_chip_model chip_inst (
        .clk      (csi_clk),
        .reset_n  (rsi_reset_n),
        .load     (coe_ctrl_load_export),
        .mod0     (coe_ctrl_mod0_export),
        .mod1     (coe_ctrl_mod1_export),
        .read_dir (read_dir),
        .si       (coe_ctrl_si_export),
        .so       (coe_ctrl_so_export),
        .rdy      (coe_ctrl_rdy_export)
    );

    always #(clk_period / 2) csi_clk = ~csi_clk;

    // ------------------------------------------------------------
    // Random bits and reference model
    // ------------------------------------------------------------
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int k = 0; k < n; k++)
        begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003)
                                       : (lfsr_state >> 1);  // Galois step
        end
        return value;
    endfunction

    // Applies one load to the reference state, returns the expected frame
    function automatic sram_io_frame_pkg::frame_t ref_transfer(
        input sram_io_regs_pkg::mode_t   mode,
        input sram_io_frame_pkg::frame_t regs);
        sram_io_frame_pkg::frame_t old_frame;
        old_frame = ref_frame;
        case (mode)
            sram_io_regs_pkg::write_scan:
            begin
                ref_frame = ref_scan;   // Scan content comes back while regs go in
                ref_scan  = regs;
            end
            sram_io_regs_pkg::read_scan:
            begin
                ref_frame = ref_scan;   // Old frame recirculates into the chip
                ref_scan  = old_frame;
            end
            sram_io_regs_pkg::mem_to_scan:
                ref_scan.data = ref_mem[ref_scan.addr];
            default:
                ref_mem[ref_scan.addr] = ref_scan.data;
        endcase
        return ref_frame;
    endfunction

    // ------------------------------------------------------------
    // Checks and reporting
    // ------------------------------------------------------------
    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            test_errors++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_frame(input sram_io_frame_pkg::frame_t exp);
        check_val("avs_sram_addr_readdata", avs_sram_addr_readdata, 32'(exp.addr));
        check_val("avs_sram_data_readdata", avs_sram_data_readdata, 32'(exp.data));
    endtask

    task automatic end_test(input string name);
        test_num++;
        $display("test %0d %s: %s, %0d errors", test_num, name,
                 (test_errors == 0) ? "pass" : "fail", test_errors);
        test_errors = 0;
    endtask

    // ------------------------------------------------------------
    // CPU side
    // ------------------------------------------------------------
    task automatic write_addr_data(input sram_io_frame_pkg::frame_t f);
        @(negedge csi_clk);
        avs_sram_addr_writedata = 32'(f.addr);
        avs_sram_data_writedata = 32'(f.data);
        avs_sram_addr_write     = 1'b1;
        avs_sram_data_write     = 1'b1;
        @(negedge csi_clk);
        avs_sram_addr_write = 1'b0;
        avs_sram_data_write = 1'b0;
        cur_regs            = f;
    endtask

    // Control write with the strobe held for hold cycles, also checks bgn retiming
    task automatic write_ctrl(input logic bgn, input logic load,
                              input sram_io_regs_pkg::mode_t mode, input int hold);
        logic [31:0] word;
        logic [1:0]  mbits;
        logic        bgn_old;
        mbits                               = mode;
        word                                = '0;
        word[sram_io_regs_pkg::idx_bgn]     = bgn;
        word[sram_io_regs_pkg::idx_load]    = load;
        word[sram_io_regs_pkg::idx_mod0]    = mbits[0];
        word[sram_io_regs_pkg::idx_mod1]    = mbits[1];
        bgn_old                             = exp_bgn;
        @(negedge csi_clk);
        avs_cpuctrl_writedata = word;
        avs_cpuctrl_write     = 1'b1;
        read_dir              = (mode == sram_io_regs_pkg::read_scan);
        @(posedge csi_clk);
        exp_mode = mbits;
        exp_bgn  = bgn;
        #1;
        check_val("coe_ctrl_bgn_export", 32'(coe_ctrl_bgn_export), 32'(bgn_old)); // Not yet
        repeat (hold - 1) @(posedge csi_clk);
        @(negedge csi_clk);
        avs_cpuctrl_write = 1'b0;
        #1;
        check_val("coe_ctrl_bgn_export", 32'(coe_ctrl_bgn_export), 32'(bgn));
    endtask

    // Waits for busy low and chip ready
    task automatic wait_idle();
        int n;
        n = 0;
        @(posedge csi_clk);
        #1;
        while ((avs_cpustat_readdata[sram_io_regs_pkg::idx_busy] ||
                !avs_cpustat_readdata[sram_io_regs_pkg::idx_rdy]) && n < frame_cycles)
        begin
            @(posedge csi_clk);
            #1;
            n++;
        end
        if (avs_cpustat_readdata[sram_io_regs_pkg::idx_busy] ||
            !avs_cpustat_readdata[sram_io_regs_pkg::idx_rdy])
        begin
            errors++;
            test_errors++;
            $display("transfer still running after %0d cycles", frame_cycles);
        end
    endtask

    task automatic run_transfer(input sram_io_regs_pkg::mode_t mode);
        write_ctrl(1'b1, 1'b1, mode, 1);
        wait_idle();
        check_frame(ref_transfer(mode, cur_regs));
    endtask

    task automatic random_regs();
        stim.addr = 9'(rand_bits(9));
        stim.data = 8'(rand_bits(8));
        write_addr_data(stim);
    endtask

    // Pin monitor: load pulses, busy cycles, mode pin rule every cycle
    always @(posedge csi_clk)
    begin
        #1;
        if (rsi_reset_n)
        begin
            if (coe_ctrl_load_export)
                load_pulses++;
            if (avs_cpustat_readdata[sram_io_regs_pkg::idx_busy])
                busy_cycles++;
            // mod1 hidden unless mod0
            check_val("{coe_ctrl_mod1_export, coe_ctrl_mod0_export}",
                      32'({coe_ctrl_mod1_export, coe_ctrl_mod0_export}),
                      32'({exp_mode[0] & exp_mode[1], exp_mode[0]}));
        end
    end

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial
    begin
        rsi_reset_n             = 1'b0;
        avs_cpuctrl_writedata   = '0;
        avs_cpuctrl_write       = 1'b0;
        avs_sram_addr_writedata = '0;
        avs_sram_addr_write     = 1'b0;
        avs_sram_data_writedata = '0;
        avs_sram_data_write     = 1'b0;
        read_dir                = 1'b0;
        exp_mode                = 2'b00;
        exp_bgn                 = 1'b0;
        ref_scan                = '0;
        ref_frame               = '0;
        cur_regs                = '0;
        for (int i = 0; i < 512; i++)
            ref_mem[i] = i[7:0] ^ i[8:1];   // Same fill as the chip
        repeat (reset_cycles) @(posedge csi_clk);
        @(negedge csi_clk);
        rsi_reset_n = 1'b1;

        // Idle state after reset
        @(posedge csi_clk);
        #1;
        check_val("coe_ctrl_bgn_export", 32'(coe_ctrl_bgn_export), 32'h0);
        check_val("coe_ctrl_load_export", 32'(coe_ctrl_load_export), 32'h0);
        check_val("coe_ctrl_mod0_export", 32'(coe_ctrl_mod0_export), 32'h0);
        check_val("coe_ctrl_mod1_export", 32'(coe_ctrl_mod1_export), 32'h0);
        check_val("coe_ctrl_si_export", 32'(coe_ctrl_si_export), 32'h0);
        check_frame('0);
        check_val("avs_cpustat_readdata", avs_cpustat_readdata, 32'h1);  // Ready, not busy
        end_test("reset state");

        random_regs();
        run_transfer(sram_io_regs_pkg::write_scan);
        run_transfer(sram_io_regs_pkg::read_scan);
        check_frame(stim);                           // Written frame comes back
        end_test("write then read scan");

        random_regs();
        first_data = stim.data;
        run_transfer(sram_io_regs_pkg::write_scan);
        run_transfer(sram_io_regs_pkg::scan_to_mem);
        stim.data = ~first_data;
        write_addr_data(stim);
        run_transfer(sram_io_regs_pkg::write_scan);  // Scan now holds other data
        run_transfer(sram_io_regs_pkg::mem_to_scan);
        run_transfer(sram_io_regs_pkg::read_scan);
        check_val("avs_sram_data_readdata", avs_sram_data_readdata, 32'(first_data));
        check_val("avs_sram_addr_readdata", avs_sram_addr_readdata, 32'(stim.addr));
        end_test("SRAM store and fetch");

        for (int m = 0; m < 4; m++)
        begin
            write_ctrl(m[0], 1'b0, sram_io_regs_pkg::mode_t'(m[1:0]), 1);
            check_val("coe_ctrl_mod0_export", 32'(coe_ctrl_mod0_export), 32'(m[0]));
            check_val("coe_ctrl_mod1_export", 32'(coe_ctrl_mod1_export),
                      m[0] ? 32'(m[1]) : 32'h0);
        end
        end_test("mode and bgn pins");

        random_regs();
        @(negedge csi_clk);
        load_pulses = 0;
        busy_cycles = 0;
        write_ctrl(1'b1, 1'b1, sram_io_regs_pkg::write_scan, 5);   // Strobe held
        wait_idle();
        @(negedge csi_clk);
        check_val("load_pulse_count", load_pulses, 1);
        check_val("busy_cycle_count", busy_cycles, sram_io_frame_pkg::frame_width);
        check_frame(ref_transfer(sram_io_regs_pkg::write_scan, cur_regs));
        end_test("held control strobe");

        random_regs();
        write_ctrl(1'b1, 1'b1, sram_io_regs_pkg::write_scan, 1);
        @(posedge csi_clk);                          // Load edge
        #1;
        check_val("avs_cpustat_readdata", avs_cpustat_readdata, 32'h2);
        check_val("avs_cpustat_readdata[0]", 32'(avs_cpustat_readdata[0]),
                  32'(coe_ctrl_rdy_export));
        repeat (3) @(posedge csi_clk);
        #1;
        check_val("avs_cpustat_readdata", avs_cpustat_readdata, 32'h3);  // Ready back, still shifting
        wait_idle();
        check_val("avs_cpustat_readdata", avs_cpustat_readdata, 32'h1);
        check_frame(ref_transfer(sram_io_regs_pkg::write_scan, cur_regs));
        end_test("status word");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    // Watchdog
    initial
    begin
        #((reset_cycles + max_frames * frame_cycles) * clk_period);
        $display("simulation ran past its time limit");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/sram_io_frame_pkg.sv
/*
 * Scan frame package for the test chip SRAM link
 * Frame geometry and the request passed from the register stage to the shifter
 */

`default_nettype none

package sram_io_frame_pkg;

    // ------------------------------------------------------------
    // Frame geometry
    // ------------------------------------------------------------
    localparam int addr_width  = 9;                       // 512 words of SRAM
    localparam int data_width  = 8;                       // One byte per word
    localparam int frame_width = addr_width + data_width; // 17 bits on the wire
    localparam int count_width = 5;                       // Holds 0..17

    // Address sits above data, bit 0 goes out first
    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] data;
    } frame_t;

    // ------------------------------------------------------------
    // Register stage to shift stage
    // ------------------------------------------------------------
    typedef struct packed {
        logic                     load;  // One-cycle start pulse
        sram_io_regs_pkg::mode_t  mode;  // Transfer mode, already updated
        frame_t                   frame; // Parallel value from addr/data regs
    } shift_req_t;

endpackage

`default_nettype wire

// File: hw/sram_io_pins.sv
/*
 * Pin stage: drives the chip control pins
 * bgn retimed on the falling edge, mode pins encoded per transfer type
 */

`timescale 1ns/1ps
`default_nettype none

module sram_io_pins
(
    input  wire logic              csi_clk,
    input  wire logic              rsi_reset_n,

    input  sram_io_regs_pkg::ctrl_t ctrl,
    input  wire logic              load,
    input  wire logic              si_bit,

    output      logic              bgn_pin,
    output      logic              load_pin,
    output      logic              mod0_pin,
    output      logic              mod1_pin,
    output      logic              si_pin
);

    logic       bgn_q;      // Chip enable, half a cycle behind
    logic [1:0] mode_bits;

    // Chip enable must not move on the rising edge
    always_ff @(negedge csi_clk)
    begin
        if (!rsi_reset_n)
            bgn_q <= 1'b0;
        else
            bgn_q <= ctrl.bgn;
    end

    assign mode_bits = ctrl.mode;

    assign bgn_pin  = bgn_q;
    assign load_pin = load;
    assign si_pin   = si_bit;
    assign mod0_pin = mode_bits[0];
    assign mod1_pin = mode_bits[0] ? mode_bits[1] : 1'b0;  // Both serial modes look like 00

endmodule

`default_nettype wire

// File: hw/sram_io_regs.sv
/*
 * Register stage: Avalon write decode for control, address and data
 * Holds the CPU registers and turns a control write into one load pulse
 */

`timescale 1ns/1ps
`default_nettype none

module sram_io_regs
(
    input  wire logic                                   csi_clk,
    input  wire logic                                   rsi_reset_n,

    input  wire logic [sram_io_regs_pkg::bus_width-1:0] cpuctrl_writedata,
    input  wire logic                                   cpuctrl_write,
    input  wire logic [sram_io_regs_pkg::bus_width-1:0] addr_writedata,
    input  wire logic                                   addr_write,
    input  wire logic [sram_io_regs_pkg::bus_width-1:0] data_writedata,
    input  wire logic                                   data_write,

    output sram_io_frame_pkg::shift_req_t               shift_req,
    output sram_io_regs_pkg::ctrl_t                     ctrl
);

    sram_io_regs_pkg::ctrl_t                      ctrl_q;
    logic [sram_io_frame_pkg::addr_width-1:0]     addr_q;  // Low 9 bits of address write
    logic [sram_io_frame_pkg::data_width-1:0]     data_q;  // Low 8 bits of data write

    logic write_seen;  // Tracker state, strobe was high last cycle
    logic load_q;      // Load pulse

    // ------------------------------------------------------------
    // Held registers
    // ------------------------------------------------------------
    always_ff @(posedge csi_clk)
    begin
        if (!rsi_reset_n)
        begin
            ctrl_q <= '0;
            addr_q <= '0;
            data_q <= '0;
        end
        else
        begin
            if (cpuctrl_write)
            begin
                ctrl_q.bgn  <= cpuctrl_writedata[sram_io_regs_pkg::idx_bgn];
                ctrl_q.mode <= sram_io_regs_pkg::mode_t'(
                                   {cpuctrl_writedata[sram_io_regs_pkg::idx_mod1],
                                    cpuctrl_writedata[sram_io_regs_pkg::idx_mod0]});
            end
            if (addr_write)
                addr_q <= addr_writedata[sram_io_frame_pkg::addr_width-1:0];
            if (data_write)
                data_q <= data_writedata[sram_io_frame_pkg::data_width-1:0];
        end
    end

    // ------------------------------------------------------------
    // Load pulse, one per write burst
    // ------------------------------------------------------------
    always_ff @(posedge csi_clk)
    begin
        if (!rsi_reset_n)
        begin
            write_seen <= 1'b0;
            load_q     <= 1'b0;
        end
        else
        begin
            write_seen <= cpuctrl_write;  // Idle again only once strobe drops
            // First cycle of a burst only
            load_q     <= cpuctrl_write & ~write_seen
                          & cpuctrl_writedata[sram_io_regs_pkg::idx_load];
        end
    end

    // Frame built straight from the held registers
    always_comb
    begin
        shift_req.load       = load_q;
        shift_req.mode       = ctrl_q.mode;
        shift_req.frame.addr = addr_q;
        shift_req.frame.data = data_q;
    end

    assign ctrl = ctrl_q;

    // Pulse never stretches, even with the strobe held
    a_load_single: assert property (@(posedge csi_clk) disable iff (!rsi_reset_n)
        load_q |=> !load_q);

endmodule

`default_nettype wire

// File: hw/sram_io_regs_pkg.sv
/*
 * CPU register map for the test chip SRAM link
 * Control and status bit positions, transfer modes, control fields
 */

`default_nettype none

package sram_io_regs_pkg;

    localparam int bus_width = 32; // Avalon data width

    // Control word bits
    localparam int idx_bgn  = 0;
    localparam int idx_load = 1;
    localparam int idx_mod0 = 2;
    localparam int idx_mod1 = 3;

    // Status word bits
    localparam int idx_rdy  = 0;   // Chip ready flag
    localparam int idx_busy = 1;   // Shift in progress

    typedef enum logic [1:0] {
        write_scan  = 2'b00,       // Serial frame into chip
        mem_to_scan = 2'b01,       // Chip SRAM to scan register
        read_scan   = 2'b10,       // Serial frame out of chip
        scan_to_mem = 2'b11        // Chip scan register to SRAM
    } mode_t;

    typedef struct packed {
        logic  bgn;
        mode_t mode;
    } ctrl_t;

endpackage

`default_nettype wire

// File: hw/sram_io_shifter.sv
/*
 * Shift stage: 17-bit frame register and bit counter
 * Parallel load for writes to the chip, serial capture of so for reads
 */

`timescale 1ns/1ps
`default_nettype none

module sram_io_shifter
(
    input  wire logic                     csi_clk,
    input  wire logic                     rsi_reset_n,

    input  sram_io_frame_pkg::shift_req_t shift_req,
    input  wire logic                     so,          // Serial out of the chip

    output      logic                     si_bit,      // Bit 0 of the frame
    output      logic                     busy,
    output sram_io_frame_pkg::frame_t     frame
);

    localparam int fw = sram_io_frame_pkg::frame_width;
    localparam int cw = sram_io_frame_pkg::count_width;

    sram_io_frame_pkg::frame_t frame_q;
    logic [cw-1:0]             count_q;   // Bits still to move
    logic [fw-1:0]             shifted;   // so enters at the top

    assign shifted = {so, frame_q[fw-1:1]};

    // ------------------------------------------------------------
    // Frame register and counter
    // ------------------------------------------------------------
    always_ff @(posedge csi_clk)
    begin
        if (!rsi_reset_n)
        begin
            frame_q <= '0;
            count_q <= '0;
        end
        else if (shift_req.load)
        begin
            case (shift_req.mode)
                sram_io_regs_pkg::write_scan:
                begin
                    frame_q <= shift_req.frame;   // Parallel load
                    count_q <= cw'(fw);           // 17 shifts follow
                end
                sram_io_regs_pkg::read_scan:
                begin
                    // Chip already drives bit 0, capture on the load edge
                    frame_q <= sram_io_frame_pkg::frame_t'(shifted);
                    count_q <= cw'(fw - 1);
                end
                default:
                begin
                    // Chip-internal move, frame and counter hold
                end
            endcase
        end
        else if (count_q != '0)
        begin
            frame_q <= sram_io_frame_pkg::frame_t'(shifted);
            count_q <= count_q - 1'b1;
        end
    end

    assign si_bit = frame_q[0];
    assign busy   = (count_q != '0);
    assign frame  = frame_q;

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    a_count_range: assert property (@(posedge csi_clk) disable iff (!rsi_reset_n)
        count_q <= cw'(fw));

    // Internal modes must not start a serial transfer
    a_internal_idle: assert property (@(posedge csi_clk) disable iff (!rsi_reset_n)
        shift_req.load && (shift_req.mode == sram_io_regs_pkg::mem_to_scan ||
                           shift_req.mode == sram_io_regs_pkg::scan_to_mem)
        |=> count_q == '0);

endmodule

`default_nettype wire

// File: hw/sram_io_top.sv
/*
 * SRAM link controller top: Avalon slave ports and chip conduit pins
 * Register stage -> shift stage -> pin stage
 */

`timescale 1ns/1ps
`default_nettype none

module sram_io_top
(
    input  wire logic                                   csi_clk,
    input  wire logic                                   rsi_reset_n,

    // Avalon slave
    input  wire logic [sram_io_regs_pkg::bus_width-1:0] avs_cpuctrl_writedata,
    input  wire logic                                   avs_cpuctrl_write,
    input  wire logic [sram_io_regs_pkg::bus_width-1:0] avs_sram_addr_writedata,
    input  wire logic                                   avs_sram_addr_write,
    input  wire logic [sram_io_regs_pkg::bus_width-1:0] avs_sram_data_writedata,
    input  wire logic                                   avs_sram_data_write,
    output      logic [sram_io_regs_pkg::bus_width-1:0] avs_cpustat_readdata,
    output      logic [sram_io_regs_pkg::bus_width-1:0] avs_sram_addr_readdata,
    output      logic [sram_io_regs_pkg::bus_width-1:0] avs_sram_data_readdata,

    // Chip conduit
    output      logic                                   coe_ctrl_bgn_export,
    output      logic                                   coe_ctrl_load_export,
    output      logic                                   coe_ctrl_mod0_export,
    output      logic                                   coe_ctrl_mod1_export,
    output      logic                                   coe_ctrl_si_export,
    input  wire logic                                   coe_ctrl_so_export,
    input  wire logic                                   coe_ctrl_rdy_export
);

    sram_io_frame_pkg::shift_req_t shift_req;
    sram_io_regs_pkg::ctrl_t       ctrl;
    sram_io_frame_pkg::frame_t     frame;
    logic                          si_bit;
    logic                          busy;

    sram_io_regs sram_io_regs_inst (
        .csi_clk           (csi_clk),
        .rsi_reset_n       (rsi_reset_n),
        .cpuctrl_writedata (avs_cpuctrl_writedata),
        .cpuctrl_write     (avs_cpuctrl_write),
        .addr_writedata    (avs_sram_addr_writedata),
        .addr_write        (avs_sram_addr_write),
        .data_writedata    (avs_sram_data_writedata),
        .data_write        (avs_sram_data_write),
        .shift_req         (shift_req),
        .ctrl              (ctrl)
    );

    sram_io_shifter sram_io_shifter_inst (
        .csi_clk     (csi_clk),
        .rsi_reset_n (rsi_reset_n),
        .shift_req   (shift_req),
        .so          (coe_ctrl_so_export),
        .si_bit      (si_bit),
        .busy        (busy),
        .frame       (frame)
    );

    sram_io_pins sram_io_pins_inst (
        .csi_clk     (csi_clk),
        .rsi_reset_n (rsi_reset_n),
        .ctrl        (ctrl),
        .load        (shift_req.load),
        .si_bit      (si_bit),
        .bgn_pin     (coe_ctrl_bgn_export),
        .load_pin    (coe_ctrl_load_export),
        .mod0_pin    (coe_ctrl_mod0_export),
        .mod1_pin    (coe_ctrl_mod1_export),
        .si_pin      (coe_ctrl_si_export)
    );

    // Status word, unused bits read as zero
    always_comb
    begin
        avs_cpustat_readdata                             = '0;
        avs_cpustat_readdata[sram_io_regs_pkg::idx_rdy]  = coe_ctrl_rdy_export;
        avs_cpustat_readdata[sram_io_regs_pkg::idx_busy] = busy;
    end

    // Last frame, zero-extended
    assign avs_sram_addr_readdata = sram_io_regs_pkg::bus_width'(frame.addr);
    assign avs_sram_data_readdata = sram_io_regs_pkg::bus_width'(frame.data);

endmodule

`default_nettype wire

// File: sram_io.f
hw/sram_io_regs_pkg.sv
hw/sram_io_frame_pkg.sv
hw/sram_io_regs.sv
hw/sram_io_shifter.sv
hw/sram_io_pins.sv
hw/sram_io_top.sv
dv/scpu_chip_model.sv
dv/sram_io_tb.sv
